/* build.f */
exec_pkg.sv
cf_unit.sv
alu_unit.sv
issue_steer.sv
flush_fsm.sv
flush_timer.sv
wb_arbiter.sv
exec_top.sv
tb_exec_top.sv

/* tb_exec_top.sv */
/*
 * Testbench for the integer execute stage
 * Reference model indexed by sequence number, LFSR stimulus,
 * concurrent assertions on writeback, squash and flush window
 */
module tb_exec_top;

  timeunit 1ns;
  timeprecision 1ps;

  import exec_pkg::*;

  localparam int p_seq_num_bits = 8;
  localparam int p_flush_cycles = 6;
  localparam int n_directed     = 8;
  localparam int n_flush        = 11;
  localparam int n_random       = 200;
  localparam int timeout_cycles = 40 * (n_directed + n_flush + n_random) + 100;

  typedef logic [p_seq_num_bits-1:0] seq_t;

  // Dispatch order for the flush test, offsets from a base number
  // Branch first, then a mix of older and younger ops
  int flush_order [n_flush] = '{2, 3, 0, 4, 1, 5, 6, 7, 8, 9, 10};

  // DUT ports
  logic      clk;
  logic      rst;
  logic      d_val;
  logic      d_rdy;
  word_t     d_pc;
  seq_t      d_seq_num;
  word_t     d_op1;
  word_t     d_op2;
  word_t     d_imm;
  reg_addr_t d_waddr;
  uop_t      d_uop;
  preg_t     d_preg;
  preg_t     d_ppreg;
  logic      w_val;
  logic      w_rdy;
  word_t     w_pc;
  seq_t      w_seq_num;
  reg_addr_t w_waddr;
  logic      w_wen;
  word_t     w_wdata;
  preg_t     w_preg;
  preg_t     w_ppreg;
  logic      squash_val;
  word_t     squash_target;
  seq_t      squash_seq_num;

  // Expected writebacks, one slot per sequence number
  logic      pending       [2**p_seq_num_bits];
  logic      exp_cf_arr    [2**p_seq_num_bits];
  logic      exp_wen_arr   [2**p_seq_num_bits];
  word_t     exp_wdata_arr [2**p_seq_num_bits];
  word_t     exp_pc_arr    [2**p_seq_num_bits];
  reg_addr_t exp_waddr_arr [2**p_seq_num_bits];
  preg_t     exp_preg_arr  [2**p_seq_num_bits];
  preg_t     exp_ppreg_arr [2**p_seq_num_bits];

  // Model state, valid for the current cycle
  int        outstanding;
  int        flush_left;
  seq_t      latched_seq;
  logic      exp_squash;
  seq_t      exp_sq_seq;
  word_t     exp_sq_target;
  logic      alt_due;
  logic      last_src_cf;

  // Lookups for the result on the writeback port
  logic      exp_hit;
  logic      exp_wen;
  word_t     exp_wdata;
  word_t     exp_pc;
  reg_addr_t exp_waddr;
  preg_t     exp_preg;
  preg_t     exp_ppreg;
  logic      src_cf;
  logic      exp_kill;

  // Stimulus state and counters
  logic [31:0] lfsr;
  logic        bp_en;
  seq_t        next_seq;
  int          errors = 0;
  int          dispatched = 0;
  int          written = 0;
  int          killed = 0;
  int          squashes = 0;
  int          cycle_count = 0;

  exec_top #(
    .p_seq_num_bits(p_seq_num_bits),
    .p_flush_cycles(p_flush_cycles)
  ) u_exec_top (.*);

  always #5 clk = ~clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      bits = {bits[30:0], lfsr[0]};
    end
    return bits;
  endfunction

  // Result rules per op
  function automatic word_t expected_wdata(uop_t uop, word_t pc, word_t a, word_t b, word_t imm);
    case (uop)
      OP_ADD:          return a + b;
      OP_SUB:          return a - b;
      OP_AND:          return a & b;
      OP_ADDI:         return a + imm;
      OP_JAL, OP_JALR: return pc + 32'd4;
      default:         return '0;
    endcase
  endfunction

  task automatic count_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    errors++;
    $display("Error %s got %h expected %h", name, got, exp);
  endtask

  task automatic count_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic print_counts();
    $display("Errors %0d, dispatched %0d, written back %0d, killed %0d, squashes %0d",
             errors, dispatched, written, killed, squashes);
  endtask

  // Advance one cycle, new inputs 1 ns after the edge
  task automatic step();
    @(posedge clk);
    #1;
    if (bp_en) begin
      w_rdy = (take_bits(2) != 0);
    end else begin
      w_rdy = 1'b1;
    end
  endtask

  // Offer one op until accepted
  // equal forces op2 to op1, so a BNE is not taken
  task automatic send_op(input uop_t uop, input logic equal, input seq_t seq);
    logic accepted;
    d_val     = 1'b1;
    d_uop     = uop;
    d_seq_num = seq;
    d_op1     = take_bits(32);
    d_op2     = equal ? d_op1 : take_bits(32);
    d_pc      = take_bits(30) << 2;
    d_imm     = take_bits(12);
    d_waddr   = reg_addr_t'(take_bits(5));
    d_preg    = preg_t'(take_bits(6));
    d_ppreg   = preg_t'(take_bits(6));
    accepted  = 1'b0;
    while (!accepted) begin
      // Ready is settled by mid-cycle
      @(negedge clk);
      accepted = d_rdy;
      step();
    end
    d_val = 1'b0;
  endtask

  // Idle until results are out and no window is open
  task automatic drain();
    while (outstanding != 0 || flush_left != 0 || exp_squash) begin
      step();
    end
    step();
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  assign exp_hit   = pending[w_seq_num];
  assign exp_wen   = exp_wen_arr[w_seq_num];
  assign exp_wdata = exp_wdata_arr[w_seq_num];
  assign exp_pc    = exp_pc_arr[w_seq_num];
  assign exp_waddr = exp_waddr_arr[w_seq_num];
  assign exp_preg  = exp_preg_arr[w_seq_num];
  assign exp_ppreg = exp_ppreg_arr[w_seq_num];
  assign src_cf    = exp_cf_arr[w_seq_num];
  assign exp_kill  = (flush_left != 0) && d_val && (d_seq_num > latched_seq);

  always @(posedge clk) begin : model
    logic kill_now;
    kill_now = (flush_left != 0) && (d_seq_num > latched_seq);
    if (rst) begin
      for (int i = 0; i < 2**p_seq_num_bits; i++) begin
        pending[i] = 1'b0;
      end
      outstanding = 0;
      flush_left  = 0;
      latched_seq = '0;
      exp_squash  = 1'b0;
      alt_due     = 1'b0;
      last_src_cf = 1'b0;
    end else begin
      // Retire
      if (w_val && w_rdy && pending[w_seq_num]) begin
        pending[w_seq_num] = 1'b0;
        // Two held results means one in each unit
        alt_due     = (outstanding == 2);
        outstanding--;
        written++;
        last_src_cf = exp_cf_arr[w_seq_num];
      end
      // Dispatch, killed ops leave no trace
      if (d_val && d_rdy) begin
        dispatched++;
        if (kill_now) begin
          killed++;
        end else begin
          pending[d_seq_num]       = 1'b1;
          exp_cf_arr[d_seq_num]    = (d_uop == OP_BNE) || (d_uop == OP_JAL) ||
                                     (d_uop == OP_JALR);
          exp_wen_arr[d_seq_num]   = (d_uop != OP_BNE);
          exp_wdata_arr[d_seq_num] = expected_wdata(d_uop, d_pc, d_op1, d_op2, d_imm);
          exp_pc_arr[d_seq_num]    = d_pc;
          exp_waddr_arr[d_seq_num] = d_waddr;
          exp_preg_arr[d_seq_num]  = d_preg;
          exp_ppreg_arr[d_seq_num] = d_ppreg;
          outstanding++;
        end
      end
      // Squash in this cycle opens the window from the next one
      if (exp_squash) begin
        latched_seq = exp_sq_seq;
        flush_left  = p_flush_cycles;
        squashes++;
      end else if (flush_left != 0) begin
        flush_left--;
      end
      // Taken BNE squashes one cycle after dispatch
      exp_squash = d_val && d_rdy && !kill_now && (d_uop == OP_BNE) && (d_op1 != d_op2);
      if (exp_squash) begin
        exp_sq_seq    = d_seq_num;
        exp_sq_target = d_pc + d_imm;
      end
    end
  end

  // ----------------------------------------
  // Assertions
  // ----------------------------------------

  a_reset: assert property (@(posedge clk) rst |=> !w_val && !squash_val && d_rdy)
    else count_failure("Outputs were not idle after reset");

  a_known: assert property (@(posedge clk) disable iff (rst) w_val |-> exp_hit)
    else count_failure($sformatf("Writeback of seq %0h that was not pending",
                                 $sampled(w_seq_num)));

  a_wen: assert property (@(posedge clk) disable iff (rst)
    w_val && exp_hit |-> w_wen == exp_wen)
    else count_mismatch("w_wen", $sampled(w_wen), $sampled(exp_wen));

  a_wdata: assert property (@(posedge clk) disable iff (rst)
    w_val && exp_hit && exp_wen |-> w_wdata == exp_wdata)
    else count_mismatch("w_wdata", $sampled(w_wdata), $sampled(exp_wdata));

  a_pc: assert property (@(posedge clk) disable iff (rst)
    w_val && exp_hit |-> w_pc == exp_pc)
    else count_mismatch("w_pc", $sampled(w_pc), $sampled(exp_pc));

  a_waddr: assert property (@(posedge clk) disable iff (rst)
    w_val && exp_hit |-> w_waddr == exp_waddr)
    else count_mismatch("w_waddr", $sampled(w_waddr), $sampled(exp_waddr));

  a_preg: assert property (@(posedge clk) disable iff (rst)
    w_val && exp_hit |-> w_preg == exp_preg)
    else count_mismatch("w_preg", $sampled(w_preg), $sampled(exp_preg));

  a_ppreg: assert property (@(posedge clk) disable iff (rst)
    w_val && exp_hit |-> w_ppreg == exp_ppreg)
    else count_mismatch("w_ppreg", $sampled(w_ppreg), $sampled(exp_ppreg));

  // Empty units, so the result shows up right away
  a_latency: assert property (@(posedge clk) disable iff (rst)
    d_val && d_rdy && !exp_kill && outstanding == 0 |=>
      w_val && w_seq_num == $past(d_seq_num))
    else count_failure("Lone dispatch was not written back in the next cycle");

  a_squash: assert property (@(posedge clk) disable iff (rst) squash_val == exp_squash)
    else count_mismatch("squash_val", $sampled(squash_val), $sampled(exp_squash));

  a_sq_target: assert property (@(posedge clk) disable iff (rst)
    squash_val && exp_squash |-> squash_target == exp_sq_target)
    else count_mismatch("squash_target", $sampled(squash_target), $sampled(exp_sq_target));

  a_sq_seq: assert property (@(posedge clk) disable iff (rst)
    squash_val && exp_squash |-> squash_seq_num == exp_sq_seq)
    else count_mismatch("squash_seq_num", $sampled(squash_seq_num), $sampled(exp_sq_seq));

  // Younger ops inside the window are swallowed at once
  a_kill: assert property (@(posedge clk) disable iff (rst) exp_kill |-> d_rdy)
    else count_mismatch("d_rdy", $sampled(d_rdy), 32'h1);

  a_stable: assert property (@(posedge clk) disable iff (rst)
    w_val && !w_rdy |=> w_val && $stable(w_seq_num) && $stable(w_wdata) &&
      $stable(w_wen) && $stable(w_waddr) && $stable(w_preg) && $stable(w_ppreg) &&
      $stable(w_pc))
    else count_failure("Writeback payload changed while stalled");

  a_alternate: assert property (@(posedge clk) disable iff (rst)
    w_val && w_rdy && alt_due |-> src_cf != last_src_cf)
    else count_failure("Arbiter granted the same unit twice while both held results");

  // ----------------------------------------
  // Timeout
  // ----------------------------------------

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout after %0d cycles with %0d results outstanding",
               cycle_count, outstanding);
      print_counts();
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin : stimulus
    seq_t base;
    uop_t uop;
    clk       = 1'b0;
    rst       = 1'b1;
    d_val     = 1'b0;
    d_pc      = '0;
    d_seq_num = '0;
    d_op1     = '0;
    d_op2     = '0;
    d_imm     = '0;
    d_waddr   = '0;
    d_uop     = OP_ADD;
    d_preg    = '0;
    d_ppreg   = '0;
    w_rdy     = 1'b1;
    lfsr      = 32'hb11;
    bp_en     = 1'b0;
    next_seq  = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    step();
    step();

    // Each op alone, BNE taken at index 4, then a not-taken BNE
    for (int i = 0; i < 7; i++) begin
      send_op(uop_t'(4'(i)), 1'b0, next_seq);
      next_seq++;
      drain();
    end
    send_op(OP_BNE, 1'b1, next_seq);
    next_seq++;
    drain();

    // Taken branch followed by older and younger ALU ops
    base = next_seq;
    for (int i = 0; i < n_flush; i++) begin
      if (i == 0) begin
        send_op(OP_BNE, 1'b0, base + seq_t'(flush_order[i]));
      end else begin
        uop = uop_t'(4'(take_bits(2)));
        send_op(uop, 1'b0, base + seq_t'(flush_order[i]));
      end
    end
    next_seq = base + seq_t'(n_flush);
    drain();

    // Random mix under back-pressure with idle gaps
    bp_en = 1'b1;
    for (int i = 0; i < n_random; i++) begin
      if (take_bits(2) == 0) begin
        step();
      end
      uop = uop_t'(4'(take_bits(3) % 7));
      send_op(uop, take_bits(1) != 0, next_seq);
      next_seq++;
    end
    bp_en = 1'b0;
    drain();

    if (killed == 0) begin
      count_failure("No dispatch was killed inside a flush window");
    end
    if (squashes == 0) begin
      count_failure("No squash was seen");
    end
    print_counts();
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* exec_top.sv */
/*
 * Integer execute stage top level
 * Steer, control-flow and ALU units, writeback merge, flush control
 */
module exec_top #(
  parameter int p_seq_num_bits = 8,
  parameter int p_flush_cycles = 6
) (
  input  logic                      clk,
  input  logic                      rst,
  // Dispatch port
  input  logic                      d_val,
  output logic                      d_rdy,
  input  exec_pkg::word_t           d_pc,
  input  logic [p_seq_num_bits-1:0] d_seq_num,
  input  exec_pkg::word_t           d_op1,
  input  exec_pkg::word_t           d_op2,
  input  exec_pkg::word_t           d_imm,
  input  exec_pkg::reg_addr_t       d_waddr,
  input  exec_pkg::uop_t            d_uop,
  input  exec_pkg::preg_t           d_preg,
  input  exec_pkg::preg_t           d_ppreg,
  // Writeback port
  output logic                      w_val,
  input  logic                      w_rdy,
  output exec_pkg::word_t           w_pc,
  output logic [p_seq_num_bits-1:0] w_seq_num,
  output exec_pkg::reg_addr_t       w_waddr,
  output logic                      w_wen,
  output exec_pkg::word_t           w_wdata,
  output exec_pkg::preg_t           w_preg,
  output exec_pkg::preg_t           w_ppreg,
  // Squash notification
  output logic                      squash_val,
  output exec_pkg::word_t           squash_target,
  output logic [p_seq_num_bits-1:0] squash_seq_num
);

  import exec_pkg::*;

  // Steer to units
  logic cf_in_val, cf_in_rdy;
  logic alu_in_val, alu_in_rdy;

  // Unit results
  logic                      cf_w_val, cf_w_rdy, cf_w_wen;
  word_t                     cf_w_pc, cf_w_wdata;
  logic [p_seq_num_bits-1:0] cf_w_seq_num;
  reg_addr_t                 cf_w_waddr;
  preg_t                     cf_w_preg, cf_w_ppreg;
  logic                      alu_w_val, alu_w_rdy, alu_w_wen;
  word_t                     alu_w_pc, alu_w_wdata;
  logic [p_seq_num_bits-1:0] alu_w_seq_num;
  reg_addr_t                 alu_w_waddr;
  preg_t                     alu_w_preg, alu_w_ppreg;

  // Flush control
  logic kill, timer_start, timer_done;

  // ----------------------------------------
  // Issue
  // ----------------------------------------

  issue_steer u_issue_steer (
    .d_val, .d_uop, .kill, .cf_in_rdy, .alu_in_rdy,
    .d_rdy, .cf_in_val, .alu_in_val
  );

  // ----------------------------------------
  // Execute units
  // ----------------------------------------

  // Payload fans out straight from the dispatch inputs
  cf_unit #(.p_seq_num_bits(p_seq_num_bits)) u_cf_unit (
    .clk, .rst,
    .in_val(cf_in_val), .in_rdy(cf_in_rdy),
    .pc(d_pc), .seq_num(d_seq_num), .op1(d_op1), .op2(d_op2), .imm(d_imm),
    .waddr(d_waddr), .uop(d_uop), .preg(d_preg), .ppreg(d_ppreg),
    .out_val(cf_w_val), .out_rdy(cf_w_rdy), .out_pc(cf_w_pc),
    .out_seq_num(cf_w_seq_num), .out_waddr(cf_w_waddr), .out_wen(cf_w_wen),
    .out_wdata(cf_w_wdata), .out_preg(cf_w_preg), .out_ppreg(cf_w_ppreg),
    .squash_val, .squash_target, .squash_seq_num
  );

  alu_unit #(.p_seq_num_bits(p_seq_num_bits)) u_alu_unit (
    .clk, .rst,
    .in_val(alu_in_val), .in_rdy(alu_in_rdy),
    .pc(d_pc), .seq_num(d_seq_num), .op1(d_op1), .op2(d_op2), .imm(d_imm),
    .waddr(d_waddr), .uop(d_uop), .preg(d_preg), .ppreg(d_ppreg),
    .out_val(alu_w_val), .out_rdy(alu_w_rdy), .out_pc(alu_w_pc),
    .out_seq_num(alu_w_seq_num), .out_waddr(alu_w_waddr), .out_wen(alu_w_wen),
    .out_wdata(alu_w_wdata), .out_preg(alu_w_preg), .out_ppreg(alu_w_ppreg)
  );

  // ----------------------------------------
  // Writeback merge
  // ----------------------------------------

  wb_arbiter #(.p_seq_num_bits(p_seq_num_bits)) u_wb_arbiter (
    .clk, .rst,
    .cf_w_val, .cf_w_rdy, .cf_w_pc, .cf_w_seq_num, .cf_w_waddr,
    .cf_w_wen, .cf_w_wdata, .cf_w_preg, .cf_w_ppreg,
    .alu_w_val, .alu_w_rdy, .alu_w_pc, .alu_w_seq_num, .alu_w_waddr,
    .alu_w_wen, .alu_w_wdata, .alu_w_preg, .alu_w_ppreg,
    .w_val, .w_rdy, .w_pc, .w_seq_num, .w_waddr,
    .w_wen, .w_wdata, .w_preg, .w_ppreg
  );

  // ----------------------------------------
  // Flush window
  // ----------------------------------------

  flush_fsm #(.p_seq_num_bits(p_seq_num_bits)) u_flush_fsm (
    .clk, .rst, .squash_val, .squash_seq_num,
    .d_val, .d_seq_num, .timer_done, .kill, .timer_start
  );

  flush_timer #(.p_flush_cycles(p_flush_cycles)) u_flush_timer (
    .clk, .rst, .start(timer_start), .done(timer_done)
  );

endmodule

/* wb_arbiter.sv */
/*
 * Writeback arbiter
 * Alternating-priority merge of both unit results onto the writeback port
 */
module wb_arbiter #(
  parameter int p_seq_num_bits = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  // Control-flow unit result
  input  logic                      cf_w_val,
  output logic                      cf_w_rdy,
  input  exec_pkg::word_t           cf_w_pc,
  input  logic [p_seq_num_bits-1:0] cf_w_seq_num,
  input  exec_pkg::reg_addr_t       cf_w_waddr,
  input  logic                      cf_w_wen,
  input  exec_pkg::word_t           cf_w_wdata,
  input  exec_pkg::preg_t           cf_w_preg,
  input  exec_pkg::preg_t           cf_w_ppreg,
  // ALU unit result
  input  logic                      alu_w_val,
  output logic                      alu_w_rdy,
  input  exec_pkg::word_t           alu_w_pc,
  input  logic [p_seq_num_bits-1:0] alu_w_seq_num,
  input  exec_pkg::reg_addr_t       alu_w_waddr,
  input  logic                      alu_w_wen,
  input  exec_pkg::word_t           alu_w_wdata,
  input  exec_pkg::preg_t           alu_w_preg,
  input  exec_pkg::preg_t           alu_w_ppreg,
  // Writeback port
  output logic                      w_val,
  input  logic                      w_rdy,
  output exec_pkg::word_t           w_pc,
  output logic [p_seq_num_bits-1:0] w_seq_num,
  output exec_pkg::reg_addr_t       w_waddr,
  output logic                      w_wen,
  output exec_pkg::word_t           w_wdata,
  output exec_pkg::preg_t           w_preg,
  output exec_pkg::preg_t           w_ppreg
);

  logic prio_alu;
  logic lock;
  logic lock_alu;
  logic sel_alu;
  logic w_xfer;

  // ----------------------------------------
  // Grant
  // ----------------------------------------

  // A stalled grant is held so the payload stays stable
  // otherwise the older loser goes first
  always_comb begin
    if (lock) begin
      sel_alu = lock_alu;
    end else begin
      sel_alu = alu_w_val & (~cf_w_val | prio_alu);
    end
  end

  assign w_xfer = w_val & w_rdy;

  // Priority flips only on a completed transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      prio_alu <= 1'b0;
    end else if (w_xfer) begin
      prio_alu <= ~sel_alu;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lock     <= 1'b0;
      lock_alu <= 1'b0;
    end else begin
      lock     <= w_val & ~w_rdy;
      lock_alu <= sel_alu;
    end
  end

  // ----------------------------------------
  // Handshake and payload mux
  // ----------------------------------------

  assign w_val     = cf_w_val | alu_w_val;
  assign cf_w_rdy  = w_rdy & ~sel_alu;
  assign alu_w_rdy = w_rdy & sel_alu;

  assign w_pc      = sel_alu ? alu_w_pc      : cf_w_pc;
  assign w_seq_num = sel_alu ? alu_w_seq_num : cf_w_seq_num;
  assign w_waddr   = sel_alu ? alu_w_waddr   : cf_w_waddr;
  assign w_wen     = sel_alu ? alu_w_wen     : cf_w_wen;
  assign w_wdata   = sel_alu ? alu_w_wdata   : cf_w_wdata;
  assign w_preg    = sel_alu ? alu_w_preg    : cf_w_preg;
  assign w_ppreg   = sel_alu ? alu_w_ppreg   : cf_w_ppreg;

endmodule

/* flush_timer.sv */
/*
 * Refill window timer
 * Down-counter with a done pulse on the last window cycle
 */
module flush_timer #(
  parameter int p_flush_cycles = 6
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  output logic done
);

  localparam int p_count_bits = $clog2(p_flush_cycles + 1);

  logic [p_count_bits-1:0] count;

  // Zero means idle; start reloads even mid-window
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (start) begin
      count <= p_count_bits'(p_flush_cycles);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // Last cycle of the window
  assign done = (count == p_count_bits'(1));

endmodule

/* flush_fsm.sv */
/*
 * Squash and flush state machine
 * Latches the squashing sequence number and kills younger dispatches
 */
module flush_fsm #(
  parameter int p_seq_num_bits = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      squash_val,
  input  logic [p_seq_num_bits-1:0] squash_seq_num,
  input  logic                      d_val,
  input  logic [p_seq_num_bits-1:0] d_seq_num,
  input  logic                      timer_done,
  output logic                      kill,
  output logic                      timer_start
);

  typedef enum logic {
    IDLE,
    FLUSH
  } state_t;

  state_t                    state;
  state_t                    state_next;
  logic [p_seq_num_bits-1:0] squash_seq_r;

  // ----------------------------------------
  // State
  // ----------------------------------------

  // A new squash wins over the end of the window
  always_comb begin
    state_next = state;
    if (squash_val) begin
      state_next = FLUSH;
    end else if (timer_done) begin
      state_next = IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Re-latched on every squash, also inside a window
  always_ff @(posedge clk) begin
    if (squash_val) begin
      squash_seq_r <= squash_seq_num;
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------

  // Start or restart the refill window
  assign timer_start = squash_val;

  // Plain unsigned compare, no wrap handling
  assign kill = (state == FLUSH) & d_val & (d_seq_num > squash_seq_r);

endmodule

/* issue_steer.sv */
/*
 * Issue steer
 * Routes each dispatched micro-op to the control-flow or ALU unit
 */
module issue_steer (
  input  logic             d_val,
  input  exec_pkg::uop_t   d_uop,
  input  logic             kill,
  input  logic             cf_in_rdy,
  input  logic             alu_in_rdy,
  output logic             d_rdy,
  output logic             cf_in_val,
  output logic             alu_in_val
);

  import exec_pkg::*;

  logic to_cf;
  logic issue;

  // Unit class from the opcode
  assign to_cf = is_ctrl_flow(d_uop);

  // Killed ops never reach a unit
  assign issue = d_val & ~kill;

  assign cf_in_val  = issue & to_cf;
  assign alu_in_val = issue & ~to_cf;

  // Killed op is swallowed in one cycle
  // otherwise wait on the targeted unit only
  always_comb begin
    if (kill) begin
      d_rdy = 1'b1;
    end else if (to_cf) begin
      d_rdy = cf_in_rdy;
    end else begin
      d_rdy = alu_in_rdy;
    end
  end

endmodule

/* alu_unit.sv */
/*
 * Integer ALU execute unit for ADD, SUB, AND and ADDI
 * One-entry input register and result generation
 */
module alu_unit #(
  parameter int p_seq_num_bits = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  // Dispatch side
  input  logic                      in_val,
  output logic                      in_rdy,
  input  exec_pkg::word_t           pc,
  input  logic [p_seq_num_bits-1:0] seq_num,
  input  exec_pkg::word_t           op1,
  input  exec_pkg::word_t           op2,
  input  exec_pkg::word_t           imm,
  input  exec_pkg::reg_addr_t       waddr,
  input  exec_pkg::uop_t            uop,
  input  exec_pkg::preg_t           preg,
  input  exec_pkg::preg_t           ppreg,
  // Result side
  output logic                      out_val,
  input  logic                      out_rdy,
  output exec_pkg::word_t           out_pc,
  output logic [p_seq_num_bits-1:0] out_seq_num,
  output exec_pkg::reg_addr_t       out_waddr,
  output logic                      out_wen,
  output exec_pkg::word_t           out_wdata,
  output exec_pkg::preg_t           out_preg,
  output exec_pkg::preg_t           out_ppreg
);

  import exec_pkg::*;

  logic                      val_r;
  word_t                     pc_r;
  logic [p_seq_num_bits-1:0] seq_num_r;
  word_t                     op1_r;
  word_t                     op2_r;
  word_t                     imm_r;
  reg_addr_t                 waddr_r;
  uop_t                      uop_r;
  preg_t                     preg_r;
  preg_t                     ppreg_r;

  // ----------------------------------------
  // Input register
  // ----------------------------------------

  // Same-cycle refill when the held result is taken
  assign in_rdy = out_rdy | ~val_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      val_r <= 1'b0;
    end else if (in_val & in_rdy) begin
      val_r <= 1'b1;
    end else if (out_val & out_rdy) begin
      val_r <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_val & in_rdy) begin
      pc_r      <= pc;
      seq_num_r <= seq_num;
      op1_r     <= op1;
      op2_r     <= op2;
      imm_r     <= imm;
      waddr_r   <= waddr;
      uop_r     <= uop;
      preg_r    <= preg;
      ppreg_r   <= ppreg;
    end
  end

  // ----------------------------------------
  // Result
  // ----------------------------------------

  always_comb begin
    case (uop_r)
      OP_ADD:  out_wdata = op1_r + op2_r;
      OP_SUB:  out_wdata = op1_r - op2_r;
      OP_AND:  out_wdata = op1_r & op2_r;
      OP_ADDI: out_wdata = op1_r + imm_r;
      default: out_wdata = '0;
    endcase
  end

  // Every ALU op writes its destination
  assign out_wen     = 1'b1;
  assign out_val     = val_r;
  assign out_pc      = pc_r;
  assign out_seq_num = seq_num_r;
  assign out_waddr   = waddr_r;
  assign out_preg    = preg_r;
  assign out_ppreg   = ppreg_r;

endmodule

/* cf_unit.sv */
/*
 * Control-flow execute unit for BNE, JAL and JALR
 * One-entry input register, branch resolution, squash pulse, link write
 */
module cf_unit #(
  parameter int p_seq_num_bits = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  // Dispatch side
  input  logic                      in_val,
  output logic                      in_rdy,
  input  exec_pkg::word_t           pc,
  input  logic [p_seq_num_bits-1:0] seq_num,
  input  exec_pkg::word_t           op1,
  input  exec_pkg::word_t           op2,
  input  exec_pkg::word_t           imm,
  input  exec_pkg::reg_addr_t       waddr,
  input  exec_pkg::uop_t            uop,
  input  exec_pkg::preg_t           preg,
  input  exec_pkg::preg_t           ppreg,
  // Result side
  output logic                      out_val,
  input  logic                      out_rdy,
  output exec_pkg::word_t           out_pc,
  output logic [p_seq_num_bits-1:0] out_seq_num,
  output exec_pkg::reg_addr_t       out_waddr,
  output logic                      out_wen,
  output exec_pkg::word_t           out_wdata,
  output exec_pkg::preg_t           out_preg,
  output exec_pkg::preg_t           out_ppreg,
  // Squash notification
  output logic                      squash_val,
  output exec_pkg::word_t           squash_target,
  output logic [p_seq_num_bits-1:0] squash_seq_num
);

  import exec_pkg::*;

  logic                      val_r;
  word_t                     pc_r;
  logic [p_seq_num_bits-1:0] seq_num_r;
  word_t                     op1_r;
  word_t                     op2_r;
  word_t                     imm_r;
  reg_addr_t                 waddr_r;
  uop_t                      uop_r;
  preg_t                     preg_r;
  preg_t                     ppreg_r;
  logic                      in_xfer;
  logic                      out_xfer;
  logic                      taken;
  logic                      squash_sent;

  // ----------------------------------------
  // Input register
  // ----------------------------------------

  assign in_xfer  = in_val & in_rdy;
  assign out_xfer = out_val & out_rdy;

  // Free when empty or when the held result leaves this cycle
  assign in_rdy = out_rdy | ~val_r;

  // Occupied until the arbiter takes the result
  always_ff @(posedge clk) begin
    if (rst) begin
      val_r <= 1'b0;
    end else if (in_xfer) begin
      val_r <= 1'b1;
    end else if (out_xfer) begin
      val_r <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      pc_r      <= pc;
      seq_num_r <= seq_num;
      op1_r     <= op1;
      op2_r     <= op2;
      imm_r     <= imm;
      waddr_r   <= waddr;
      uop_r     <= uop;
      preg_r    <= preg;
      ppreg_r   <= ppreg;
    end
  end

  // ----------------------------------------
  // Branch resolution and squash
  // ----------------------------------------

  // Only BNE can redirect; jumps are predicted correctly upstream
  assign taken = (uop_r == OP_BNE) && (op1_r != op2_r);

  // Low only in the first cycle after a new op is loaded
  always_ff @(posedge clk) begin
    if (rst) begin
      squash_sent <= 1'b0;
    end else begin
      squash_sent <= ~in_xfer;
    end
  end

  // One-cycle pulse, even if the result is held longer
  assign squash_val     = val_r & taken & ~squash_sent;
  assign squash_target  = pc_r + imm_r;
  assign squash_seq_num = seq_num_r;

  // ----------------------------------------
  // Result port
  // ----------------------------------------

  // Branches write nothing, jumps write the link value
  assign out_wen     = (uop_r == OP_JAL) || (uop_r == OP_JALR);
  assign out_wdata   = pc_r + link_offset;
  assign out_val     = val_r;
  assign out_pc      = pc_r;
  assign out_seq_num = seq_num_r;
  assign out_waddr   = waddr_r;
  assign out_preg    = preg_r;
  assign out_ppreg   = ppreg_r;

endmodule

/* exec_pkg.sv */
/*
 * Shared definitions for the integer execute stage
 * Width typedefs, micro-op encoding and unit classification
 */
package exec_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------

  // Data word and pc
  typedef logic [31:0] word_t;

  // Architectural register index
  typedef logic [4:0] reg_addr_t;

  // Physical register index
  typedef logic [5:0] preg_t;

  // Link value is pc plus one instruction
  localparam word_t link_offset = 32'd4;

  // ----------------------------------------
  // Micro-ops
  // ----------------------------------------

  // ALU ops first, control flow after
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_ADDI = 4'd3,
    OP_BNE  = 4'd4,
    OP_JAL  = 4'd5,
    OP_JALR = 4'd6
  } uop_t;

  // Ops handled by the control-flow unit
  function automatic logic is_ctrl_flow(uop_t uop);
    case (uop)
      OP_BNE, OP_JAL, OP_JALR: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage
